// File: project.f
logic/usys_pkg.sv
logic/unary_encoder.sv
logic/pe_cell.sv
logic/pe_row.sv
logic/psum_collector.sv
logic/usys_top.sv
sim/tb_usys.sv

// File: Makefile
# Verilator build and run for the unary systolic row

VERILATOR ?= verilator
TOP       ?= tb_usys
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= sim passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: sim/tb_usys.sv
module tb_usys;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int DW         = usys_pkg::DATA_W;
    localparam int ACC_W      = usys_pkg::ACC_W;
    localparam int IDX_W      = DW - 1;
    localparam int COLS       = 4;
    localparam int STREAM_LEN = 1 << IDX_W;
    localparam int NUM_JOBS   = 8;
    localparam int MAX_ACTS   = 6;
    localparam int RAND_JOB   = 7;

    logic                    clk = 1'b0;
    logic                    rst_n_i;
    logic                    cmd_valid_i;
    usys_pkg::usys_cmd_t     cmd_i;
    usys_pkg::usys_sum_vec_t bias_i;
    logic                    busy_o;
    usys_pkg::usys_sum_vec_t res_o;
    logic                    res_valid_o;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Job table with one row per job
    // Weights are in load order, so the last one ends up in column 0

    int n_w_tab   [NUM_JOBS] = '{4, 0, 4, 4, 4, 0, 4, 4};   // Weights loaded
    int n_act_tab [NUM_JOBS] = '{1, 1, 1, 3, 1, 1, 5, 6};   // MAC commands
    int w_tab [NUM_JOBS][COLS] = '{
        '{5, 0, -7, 9},
        '{0, 0, 0, 0},
        '{127, 127, -127, 127},
        '{127, 100, -33, 1},
        '{50, -50, 90, -90},
        '{0, 0, 0, 0},
        '{64, -127, 3, -77},
        '{0, 0, 0, 0}                                         // LCG row
    };
    int act_tab [NUM_JOBS][MAX_ACTS] = '{
        '{1, 0, 0, 0, 0, 0},
        '{-1, 0, 0, 0, 0, 0},
        '{127, 0, 0, 0, 0, 0},
        '{0, 127, -128, 0, 0, 0},
        '{70, 0, 0, 0, 0, 0},
        '{-70, 0, 0, 0, 0, 0},
        '{30, -5, 100, -128, 64, 0},
        '{0, 0, 0, 0, 0, 0}
    };
    int bias_tab [NUM_JOBS][COLS] = '{
        '{0, 0, 0, 0},
        '{0, 0, 0, 0},
        '{0, 0, 0, 0},
        '{10, -20, 30, -40},
        '{100, -100, 0, 7},
        '{100, -100, 0, 7},
        '{-1, 2, -3, 4},
        '{0, 0, 0, 0}
    };

    usys_pkg::usys_weight_t model_w   [COLS];
    int                     model_acc [COLS];
    logic [31:0]            rng;
    int                     cycle_cnt   = 0;
    int                     cycle_limit = 0;

    usys_top #(
        .DATA_W (DW),
        .ACC_W  (ACC_W),
        .COLS   (COLS)
    ) dut0 (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .cmd_valid_i (cmd_valid_i),
        .cmd_i       (cmd_i),
        .bias_i      (bias_i),
        .busy_o      (busy_o),
        .res_o       (res_o),
        .res_valid_o (res_valid_o)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            report_failure();
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model and checks

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic usys_pkg::usys_weight_t to_weight(input int v);
        usys_pkg::usys_weight_t w;
        w.sign = (v < 0);
        w.mag  = IDX_W'((v < 0) ? -v : v);                    // Sign-magnitude
        return w;
    endfunction

    // Stream slots where the activation bit and the weight compare are both true
    function automatic int unary_count(input int amag, input int wmag);
        int cnt;
        cnt = 0;
        for (int t = 0; t < STREAM_LEN; t++) begin
            if (t < amag && int'(usys_pkg::bit_rev(IDX_W'(t))) < wmag) begin
                cnt++;
            end
        end
        return cnt;
    endfunction

    task automatic report_failure();
        $display("sim failed");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_sum(input usys_pkg::usys_sum_vec_t got,
                             input usys_pkg::usys_sum_vec_t want, input string what);
        if (got !== want) begin
            $display("ERROR at %0d ns: %s, res_o differs from the model", $time, what);
            for (int j = 0; j < COLS; j++) begin
                $display("  col %0d got %0d want %0d", j, $signed(got[j]), $signed(want[j]));
            end
            report_failure();
        end
    endtask

    task automatic check_busy(input logic got, input logic want, input string what);
        if (got !== want) begin
            $display("ERROR at %0d ns: %s, busy_o is %b, want %b", $time, what, got, want);
            report_failure();
        end
    endtask

    task automatic check_valid(input logic got, input logic want, input string what);
        if (got !== want) begin
            $display("ERROR at %0d ns: %s, res_valid_o is %b, want %b", $time, what, got, want);
            report_failure();
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Command drivers

    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    task automatic go_idle();
        cmd_valid_i = 1'b0;
        cmd_i       = '0;
    endtask

    task automatic load_weight(input int v);
        cmd_valid_i          = 1'b1;
        cmd_i.op             = usys_pkg::OP_LOAD_W;
        cmd_i.payload.weight = to_weight(v);
        next_cycle();
        go_idle();
        for (int j = COLS - 1; j > 0; j--) begin
            model_w[j] = model_w[j-1];                          // Row shifts right
        end
        model_w[0] = to_weight(v);
        check_busy(busy_o, 1'b0, "after OP_LOAD_W");
    endtask

    task automatic stream_activation(input int a);
        int amag;
        int cnt;
        amag                    = (a < 0) ? -a : a;         // -128 stays 128
        cmd_valid_i             = 1'b1;
        cmd_i.op                = usys_pkg::OP_MAC;
        cmd_i.payload.act.value = DW'(a);
        next_cycle();
        go_idle();
        for (int k = 0; k < STREAM_LEN + COLS; k++) begin
            check_busy(busy_o, 1'b1, "during OP_MAC stream and drain");
            check_valid(res_valid_o, 1'b0, "during OP_MAC");
            next_cycle();
        end
        check_busy(busy_o, 1'b0, "after stream drain");
        for (int j = 0; j < COLS; j++) begin
            cnt = unary_count(amag, int'(model_w[j].mag));
            if ((a < 0) ^ model_w[j].sign) begin
                model_acc[j] -= cnt;
            end else begin
                model_acc[j] += cnt;
            end
        end
    endtask

    task automatic collect_results(input int jb);
        usys_pkg::usys_sum_vec_t want;
        want = '0;
        for (int j = 0; j < COLS; j++) begin
            want[j] = ACC_W'(bias_tab[jb][j] + model_acc[j]);
        end
        cmd_valid_i   = 1'b1;
        cmd_i.op      = usys_pkg::OP_DONE;
        cmd_i.payload = '0;
        next_cycle();
        go_idle();
        for (int k = 1; k < COLS + 2; k++) begin
            check_valid(res_valid_o, 1'b0, "before result pulse");
            next_cycle();
        end
        check_valid(res_valid_o, 1'b1, "COLS+2 cycles after OP_DONE");
        check_sum(res_o, want, $sformatf("job %0d", jb));
        next_cycle();
        check_valid(res_valid_o, 1'b0, "after result pulse");
        for (int j = 0; j < COLS; j++) begin
            model_acc[j] = 0;
        end
    endtask

    initial begin
        rst_n_i = 1'b0;
        go_idle();
        bias_i = '0;
        rng    = 32'hd9b5_2924;
        for (int j = 0; j < COLS; j++) begin
            model_w[j]   = '0;
            model_acc[j] = 0;
            rng = lcg_next(rng);
            w_tab[RAND_JOB][j]    = rng[31] ? -int'(rng[30:24]) : int'(rng[30:24]);
            bias_tab[RAND_JOB][j] = int'($signed(rng[15:0]));
        end
        for (int k = 0; k < MAX_ACTS; k++) begin
            rng = lcg_next(rng);
            act_tab[RAND_JOB][k] = int'($signed(rng[23:16]));
        end
        cycle_limit = 200;
        for (int jb = 0; jb < NUM_JOBS; jb++) begin
            cycle_limit += (n_act_tab[jb] + 1) * (STREAM_LEN + COLS + 8);
        end

        repeat (16) @(posedge clk);
        #5;
        rst_n_i = 1'b1;
        check_busy(busy_o, 1'b0, "after reset");
        check_valid(res_valid_o, 1'b0, "after reset");

        for (int jb = 0; jb < NUM_JOBS; jb++) begin
            bias_i = '0;
            for (int j = 0; j < COLS; j++) begin
                bias_i[j] = ACC_W'(bias_tab[jb][j]);
            end
            for (int k = 0; k < n_w_tab[jb]; k++) begin
                load_weight(w_tab[jb][k]);
            end
            for (int k = 0; k < n_act_tab[jb]; k++) begin
                stream_activation(act_tab[jb][k]);
            end
            collect_results(jb);
            $display("Job %0d results match the model", jb);
        end

        $display("sim passed");
        $finish;
    end

endmodule

// File: logic/usys_top.sv
module usys_top #(
    parameter int DATA_W = usys_pkg::DATA_W,
    parameter int ACC_W  = usys_pkg::ACC_W,
    parameter int COLS   = 4
) (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    cmd_valid_i,
    input  usys_pkg::usys_cmd_t     cmd_i,
    input  usys_pkg::usys_sum_vec_t bias_i,
    output logic                    busy_o,
    output usys_pkg::usys_sum_vec_t res_o,
    output logic                    res_valid_o
);

    usys_pkg::usys_ctrl_t    ctrl;
    logic                    act_sign;
    logic                    act_bit;
    logic [DATA_W-2:0]       rand_idx;
    usys_pkg::usys_weight_t  weight;
    usys_pkg::usys_sum_vec_t sum_vec;
    logic [COLS-1:0]         sum_valid_vec;

    unary_encoder #(
        .DATA_W (DATA_W),
        .COLS   (COLS)
    ) u_enc (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .cmd_valid_i (cmd_valid_i),
        .cmd_i       (cmd_i),
        .ctrl_o      (ctrl),
        .act_sign_o  (act_sign),
        .act_bit_o   (act_bit),
        .rand_idx_o  (rand_idx),
        .weight_o    (weight),
        .busy_o      (busy_o)
    );

    pe_row #(
        .DATA_W (DATA_W),
        .ACC_W  (ACC_W),
        .COLS   (COLS)
    ) u_row (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .ctrl_i          (ctrl),
        .act_sign_i      (act_sign),
        .act_bit_i       (act_bit),
        .rand_idx_i      (rand_idx),
        .weight_i        (weight),
        .bias_i          (bias_i),
        .sum_vec_o       (sum_vec),
        .sum_valid_vec_o (sum_valid_vec)
    );

    psum_collector #(
        .ACC_W (ACC_W),
        .COLS  (COLS)
    ) u_coll (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .sum_vec_i       (sum_vec),
        .sum_valid_vec_i (sum_valid_vec),
        .res_o           (res_o),
        .res_valid_o     (res_valid_o)
    );

endmodule

// File: logic/psum_collector.sv
module psum_collector #(
    parameter int ACC_W = usys_pkg::ACC_W,
    parameter int COLS  = 4
) (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  usys_pkg::usys_sum_vec_t sum_vec_i,
    input  logic [COLS-1:0]         sum_valid_vec_i,
    output usys_pkg::usys_sum_vec_t res_o,
    output logic                    res_valid_o
);

    logic signed [ACC_W-1:0] cap_q [COLS];
    logic                    res_valid_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Per-column capture

    for (genvar j = 0; j < COLS; j++) begin : g_cap
        always_ff @(posedge clk or negedge rst_n_i) begin
            if (!rst_n_i) begin
                cap_q[j] <= '0;
            end else if (sum_valid_vec_i[j]) begin
                cap_q[j] <= sum_vec_i[j];
            end
        end
    end

    // Last column closes the skewed wave
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            res_valid_q <= 1'b0;
        end else begin
            res_valid_q <= sum_valid_vec_i[COLS-1];
        end
    end

    always_comb begin
        res_o = '0;
        for (int j = 0; j < COLS; j++) begin
            res_o[j] = cap_q[j];
        end
    end

    assign res_valid_o = res_valid_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Strobe ordering across the row

    for (genvar j = 1; j < COLS; j++) begin : g_order
        a_next_col: assert property (@(posedge clk) disable iff (!rst_n_i)
            sum_valid_vec_i[j-1] |=> sum_valid_vec_i[j]);

        a_prev_col: assert property (@(posedge clk) disable iff (!rst_n_i)
            sum_valid_vec_i[j] |-> $past(sum_valid_vec_i[j-1]));
    end

endmodule

// File: logic/pe_row.sv
module pe_row #(
    parameter int DATA_W = usys_pkg::DATA_W,
    parameter int ACC_W  = usys_pkg::ACC_W,
    parameter int COLS   = 4
) (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  usys_pkg::usys_ctrl_t    ctrl_i,
    input  logic                    act_sign_i,
    input  logic                    act_bit_i,
    input  logic [DATA_W-2:0]       rand_idx_i,
    input  usys_pkg::usys_weight_t  weight_i,
    input  usys_pkg::usys_sum_vec_t bias_i,
    output usys_pkg::usys_sum_vec_t sum_vec_o,
    output logic [COLS-1:0]         sum_valid_vec_o
);

    usys_pkg::usys_ctrl_t   ctrl_link     [COLS+1];
    logic                   act_sign_link [COLS+1];
    logic                   act_bit_link  [COLS+1];
    logic [DATA_W-2:0]      rand_link     [COLS+1];
    usys_pkg::usys_weight_t weight_link   [COLS+1];
    logic signed [ACC_W-1:0] sum_col      [COLS];

    assign ctrl_link[0]     = ctrl_i;
    assign act_sign_link[0] = act_sign_i;
    assign act_bit_link[0]  = act_bit_i;
    assign rand_link[0]     = rand_idx_i;
    assign weight_link[0]   = weight_i;

    for (genvar j = 0; j < COLS; j++) begin : g_col
        usys_pkg::usys_ctrl_t ctrl_in;

        always_comb begin
            ctrl_in      = ctrl_link[j];
            ctrl_in.en_w = ctrl_i.en_w;               // Broadcast so all weights shift
        end

        pe_cell #(
            .DATA_W (DATA_W),
            .ACC_W  (ACC_W)
        ) u_cell (
            .clk         (clk),
            .rst_n_i     (rst_n_i),
            .ctrl_i      (ctrl_in),
            .act_sign_i  (act_sign_link[j]),
            .act_bit_i   (act_bit_link[j]),
            .rand_idx_i  (rand_link[j]),
            .weight_i    (weight_link[j]),
            .sum_i       (bias_i[j]),
            .ctrl_o      (ctrl_link[j+1]),
            .act_sign_o  (act_sign_link[j+1]),
            .act_bit_o   (act_bit_link[j+1]),
            .rand_idx_o  (rand_link[j+1]),
            .weight_o    (weight_link[j+1]),
            .sum_o       (sum_col[j]),
            .sum_valid_o (sum_valid_vec_o[j])
        );
    end

    always_comb begin
        sum_vec_o = '0;                               // Unused columns read zero
        for (int j = 0; j < COLS; j++) begin
            sum_vec_o[j] = sum_col[j];
        end
    end

endmodule

// File: logic/pe_cell.sv
module pe_cell #(
    parameter int DATA_W = usys_pkg::DATA_W,
    parameter int ACC_W  = usys_pkg::ACC_W
) (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  usys_pkg::usys_ctrl_t    ctrl_i,
    input  logic                    act_sign_i,
    input  logic                    act_bit_i,
    input  logic [DATA_W-2:0]       rand_idx_i,
    input  usys_pkg::usys_weight_t  weight_i,
    input  logic signed [ACC_W-1:0] sum_i,
    output usys_pkg::usys_ctrl_t    ctrl_o,
    output logic                    act_sign_o,
    output logic                    act_bit_o,
    output logic [DATA_W-2:0]       rand_idx_o,
    output usys_pkg::usys_weight_t  weight_o,
    output logic signed [ACC_W-1:0] sum_o,
    output logic                    sum_valid_o
);

    usys_pkg::usys_ctrl_t   ctrl_q;
    logic                   act_sign_q;
    logic                   act_bit_q;
    logic [DATA_W-2:0]      rand_q;
    usys_pkg::usys_weight_t weight_q;
    logic signed [ACC_W-1:0] acc_q;
    logic signed [ACC_W:0]  acc_wide;
    logic signed [ACC_W:0]  acc_step;
    logic                   prod;
    logic                   neg;
    logic signed [ACC_W-1:0] sum_q;
    logic                   sum_valid_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Input bit and weight registers

    // The last stream slot never fires since its index is all ones
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            act_sign_q <= 1'b0;
            act_bit_q  <= 1'b0;
        end else if (ctrl_i.clr_i) begin
            act_sign_q <= 1'b0;
            act_bit_q  <= 1'b0;
        end else if (ctrl_i.en_i) begin
            act_sign_q <= act_sign_i;
            act_bit_q  <= act_bit_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            weight_q <= '0;
        end else if (ctrl_i.en_w) begin
            weight_q <= weight_i;                     // Shift from left neighbour
        end
    end

    always_ff @(posedge clk) begin
        rand_q <= rand_idx_i;                         // Aligned with act_bit_q
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Unary multiply and signed count

    assign prod     = act_bit_q && (rand_q < weight_q.mag);
    assign neg      = act_sign_q ^ weight_q.sign;
    assign acc_wide = {acc_q[ACC_W-1], acc_q};
    assign acc_step = neg ? acc_wide - (ACC_W + 1)'(1) : acc_wide + (ACC_W + 1)'(1);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            acc_q <= '0;
        end else if (ctrl_i.mac_done) begin
            acc_q <= '0;
        end else if (ctrl_q.en_o && prod) begin
            acc_q <= acc_step[ACC_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sum_q       <= '0;
            sum_valid_q <= 1'b0;
        end else begin
            sum_valid_q <= ctrl_i.mac_done;
            if (ctrl_i.mac_done) begin
                sum_q <= sum_i + acc_q;               // Bias plus count
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ctrl_q <= '0;
        end else begin
            ctrl_q <= ctrl_i;
        end
    end

    assign ctrl_o      = ctrl_q;
    assign act_sign_o  = act_sign_q;
    assign act_bit_o   = act_bit_q;
    assign rand_idx_o  = rand_q;
    assign weight_o    = weight_q;
    assign sum_o       = sum_q;
    assign sum_valid_o = sum_valid_q;

    a_acc_range: assert property (@(posedge clk) disable iff (!rst_n_i)
        (ctrl_q.en_o && prod) |-> (acc_step[ACC_W] == acc_step[ACC_W-1]));

endmodule

// File: logic/unary_encoder.sv
module unary_encoder #(
    parameter int DATA_W = usys_pkg::DATA_W,
    parameter int COLS   = 4
) (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   cmd_valid_i,
    input  usys_pkg::usys_cmd_t    cmd_i,
    output usys_pkg::usys_ctrl_t   ctrl_o,
    output logic                   act_sign_o,
    output logic                   act_bit_o,
    output logic [DATA_W-2:0]      rand_idx_o,
    output usys_pkg::usys_weight_t weight_o,
    output logic                   busy_o
);

    localparam int STREAM_LEN = 1 << (DATA_W - 1);
    localparam int BUSY_LEN   = STREAM_LEN + COLS;   // Stream plus row drain
    localparam int CNT_W      = $clog2(BUSY_LEN + 1);

    logic                     busy_q;
    logic [CNT_W-1:0]         cnt_q;
    logic [DATA_W-1:0]        mag_q;
    logic                     sign_q;
    logic                     en_w_q;
    logic                     done_q;
    usys_pkg::usys_weight_t   weight_q;
    logic                     start;
    logic                     stream;
    logic [DATA_W-2:0]        t_idx;
    logic signed [DATA_W-1:0] act_val;
    logic [DATA_W-1:0]        act_mag;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Command decode

    assign start   = cmd_valid_i && (cmd_i.op == usys_pkg::OP_MAC) && !busy_q;
    assign act_val = cmd_i.payload.act.value;
    assign act_mag = act_val[DATA_W-1] ? DATA_W'(-act_val) : DATA_W'(act_val); // -128 gives 128

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
            en_w_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            en_w_q <= cmd_valid_i && (cmd_i.op == usys_pkg::OP_LOAD_W);
            done_q <= cmd_valid_i && (cmd_i.op == usys_pkg::OP_DONE);
            if (start) begin
                busy_q <= 1'b1;
                cnt_q  <= '0;
            end else if (busy_q) begin
                if (cnt_q == CNT_W'(BUSY_LEN - 1)) begin
                    busy_q <= 1'b0;                   // Drain finished
                end
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mag_q  <= act_mag;
            sign_q <= act_val[DATA_W-1];
        end
        if (cmd_valid_i && (cmd_i.op == usys_pkg::OP_LOAD_W)) begin
            weight_q <= cmd_i.payload.weight;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Temporal code and random index

    assign stream = busy_q && (cnt_q < CNT_W'(STREAM_LEN));
    assign t_idx  = cnt_q[DATA_W-2:0];

    always_comb begin
        ctrl_o          = '0;
        ctrl_o.en_i     = stream;
        ctrl_o.clr_i    = stream && (cnt_q == CNT_W'(STREAM_LEN - 1));
        ctrl_o.en_w     = en_w_q;
        ctrl_o.en_o     = stream;
        ctrl_o.mac_done = done_q;
    end

    assign act_sign_o = sign_q;
    assign act_bit_o  = stream && ({1'b0, t_idx} < mag_q);   // Ones first, then zeros
    assign rand_idx_o = usys_pkg::bit_rev(t_idx);
    assign weight_o   = weight_q;
    assign busy_o     = busy_q;

    a_no_cmd_busy: assert property (@(posedge clk) disable iff (!rst_n_i)
        cmd_valid_i |-> !busy_q);

    a_clr_done: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(ctrl_o.clr_i && ctrl_o.mac_done));

endmodule

// File: logic/usys_pkg.sv
package usys_pkg;

    localparam int DATA_W   = 8;
    localparam int ACC_W    = 20;
    localparam int COLS_MAX = 8;

    typedef enum logic [1:0] {
        OP_NOP    = 2'd0,
        OP_LOAD_W = 2'd1,
        OP_MAC    = 2'd2,
        OP_DONE   = 2'd3
    } usys_op_e;

    typedef struct packed {
        logic              sign;
        logic [DATA_W-2:0] mag;
    } usys_weight_t;

    typedef struct packed {
        logic signed [DATA_W-1:0] value;
    } usys_act_t;

    typedef union packed {
        usys_weight_t weight;   // OP_LOAD_W view
        usys_act_t    act;      // OP_MAC view
    } usys_payload_u;

    typedef struct packed {
        usys_op_e      op;
        usys_payload_u payload;
    } usys_cmd_t;

    typedef struct packed {
        logic en_i;
        logic clr_i;
        logic en_w;
        logic en_o;
        logic mac_done;
    } usys_ctrl_t;

    typedef logic signed [COLS_MAX-1:0][ACC_W-1:0] usys_sum_vec_t;

    // Bit reverse of the stream counter gives a van der Corput random index
    function automatic logic [DATA_W-2:0] bit_rev(input logic [DATA_W-2:0] val);
        logic [DATA_W-2:0] rev;
        for (int i = 0; i < DATA_W - 1; i++) begin
            rev[i] = val[DATA_W-2-i];
        end
        return rev;
    endfunction

endpackage
